/* hw/cpuTypesPkg.sv */
package cpuTypesPkg;

    // ****************************************
    // Basic widths.
    // ****************************************
    typedef logic [31:0] word_t;     // Data word, address or instruction.
    typedef logic [4:0]  regAddr_t;  // Register index.

    // ****************************************
    // Instruction encodings.
    // ****************************************
    typedef enum logic [5:0] {
        RTYPE = 6'b000000,
        J     = 6'b000010,
        JAL   = 6'b000011,
        BEQ   = 6'b000100,
        BNE   = 6'b000101,
        ADDI  = 6'b001000,
        ADDIU = 6'b001001,
        SLTI  = 6'b001010,
        SLTIU = 6'b001011,
        ANDI  = 6'b001100,
        ORI   = 6'b001101,
        XORI  = 6'b001110,
        LUI   = 6'b001111,
        LW    = 6'b100011,
        SW    = 6'b101011,
        LL    = 6'b110000,
        SC    = 6'b111000,
        HALT  = 6'b111111
    } opcode_t;

    typedef enum logic [5:0] {
        SLLV = 6'b000100,
        SRLV = 6'b000110,
        JR   = 6'b001000,
        ADD  = 6'b100000,
        ADDU = 6'b100001,
        SUB  = 6'b100010,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        NOR  = 6'b100111,
        SLT  = 6'b101010,
        SLTU = 6'b101011
    } funct_t;

    // ****************************************
    // Datapath selects.
    // ****************************************
    typedef enum logic [3:0] {
        ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
        ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
    } aluOp_t;

    typedef enum logic [1:0] {REGSRC_ALU, REGSRC_MEM, REGSRC_LUI, REGSRC_NPC} regSrc_t;
    typedef enum logic [1:0] {REGDST_RD, REGDST_RT, REGDST_RA} regDst_t;  // RA is register 31.
    typedef enum logic {ALUSRC_REG, ALUSRC_IMM} aluSrc_t;
    typedef enum logic {ZERO_EXT, SIGN_EXT} extSel_t;
    typedef enum logic [2:0] {PCSRC_PC4, PCSRC_REG, PCSRC_BEQ, PCSRC_BNE, PCSRC_JAL} pcSrc_t;

endpackage

/* hw/controlUnitIf.sv */
`timescale 1ns/1ps

interface controlUnitIf;
    import cpuTypesPkg::*;

    opcode_t opcode;
    funct_t  funct;

    regSrc_t regSrc;
    regDst_t regDst;
    logic    regWen;
    aluSrc_t aluSrc;
    extSel_t extSel;
    logic    dRen;
    logic    dWen;
    aluOp_t  aluOp;
    logic    halt;
    pcSrc_t  pcSrc;
    logic    atomic;  // LL or SC access.

    modport cu (
        input  opcode, funct,
        output regSrc, regDst, regWen, aluSrc, extSel, dRen, dWen, aluOp, halt, pcSrc, atomic
    );
    modport op (input extSel);
    modport ex (
        input regSrc, regDst, regWen, aluSrc, extSel, dRen, dWen, aluOp, halt, pcSrc, atomic
    );
endinterface

/* hw/operandIf.sv */
`timescale 1ns/1ps

interface operandIf;
    import cpuTypesPkg::*;

    word_t    rsData;
    word_t    rtData;
    word_t    immExt;

    // Register file write port.
    logic     wen;
    regAddr_t wAddr;
    word_t    wData;

    modport op (output rsData, rtData, immExt, input wen, wAddr, wData);
    modport ex (input rsData, rtData, immExt, output wen, wAddr, wData);
endinterface

/* hw/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    controlUnitIf.cu cuif
);
    import cpuTypesPkg::*;

    always_comb begin
        // Defaults describe a no-op that falls through to PC+4.
        cuif.regSrc = REGSRC_ALU;
        cuif.regDst = REGDST_RD;
        cuif.regWen = 1'b0;
        cuif.aluSrc = ALUSRC_REG;
        cuif.extSel = ZERO_EXT;
        cuif.dRen   = 1'b0;
        cuif.dWen   = 1'b0;
        cuif.aluOp  = ALU_SLL;
        cuif.halt   = 1'b0;
        cuif.pcSrc  = PCSRC_PC4;
        cuif.atomic = 1'b0;

        case (cuif.opcode)
            RTYPE: begin
                cuif.regWen = 1'b1;
                case (cuif.funct)
                    SLLV:      cuif.aluOp = ALU_SLL;
                    SRLV:      cuif.aluOp = ALU_SRL;
                    ADD, ADDU: cuif.aluOp = ALU_ADD;
                    SUB, SUBU: cuif.aluOp = ALU_SUB;
                    AND:       cuif.aluOp = ALU_AND;
                    OR:        cuif.aluOp = ALU_OR;
                    XOR:       cuif.aluOp = ALU_XOR;
                    NOR:       cuif.aluOp = ALU_NOR;
                    SLT:       cuif.aluOp = ALU_SLT;
                    SLTU:      cuif.aluOp = ALU_SLTU;
                    JR: begin
                        cuif.regWen = 1'b0;
                        cuif.pcSrc  = PCSRC_REG;
                    end
                    default:   cuif.aluOp = ALU_SLL;
                endcase
            end
            BEQ, BNE: begin
                cuif.extSel = SIGN_EXT;  // Offset is signed.
                cuif.aluOp  = ALU_SUB;   // Zero result means equal.
                cuif.pcSrc  = (cuif.opcode == BEQ) ? PCSRC_BEQ : PCSRC_BNE;
            end
            ADDI, ADDIU, SLTI, SLTIU: begin
                cuif.regDst = REGDST_RT;
                cuif.regWen = 1'b1;
                cuif.aluSrc = ALUSRC_IMM;
                cuif.extSel = SIGN_EXT;
                case (cuif.opcode)
                    SLTI:    cuif.aluOp = ALU_SLT;
                    SLTIU:   cuif.aluOp = ALU_SLTU;
                    default: cuif.aluOp = ALU_ADD;
                endcase
            end
            ANDI, ORI, XORI: begin
                cuif.regDst = REGDST_RT;
                cuif.regWen = 1'b1;
                cuif.aluSrc = ALUSRC_IMM;
                case (cuif.opcode)
                    ANDI:    cuif.aluOp = ALU_AND;
                    ORI:     cuif.aluOp = ALU_OR;
                    default: cuif.aluOp = ALU_XOR;
                endcase
            end
            LUI: begin
                cuif.regSrc = REGSRC_LUI;
                cuif.regDst = REGDST_RT;
                cuif.regWen = 1'b1;
            end
            LW, LL: begin
                cuif.regSrc = REGSRC_MEM;
                cuif.regDst = REGDST_RT;
                cuif.regWen = 1'b1;
                cuif.aluSrc = ALUSRC_IMM;
                cuif.extSel = SIGN_EXT;
                cuif.dRen   = 1'b1;
                cuif.aluOp  = ALU_ADD;
                cuif.atomic = (cuif.opcode == LL);
            end
            SW, SC: begin
                cuif.aluSrc = ALUSRC_IMM;
                cuif.extSel = SIGN_EXT;
                cuif.dWen   = 1'b1;
                cuif.aluOp  = ALU_ADD;
                cuif.atomic = (cuif.opcode == SC);  // SC leaves rt untouched.
            end
            J: cuif.pcSrc = PCSRC_JAL;
            JAL: begin
                cuif.regSrc = REGSRC_NPC;
                cuif.regDst = REGDST_RA;
                cuif.regWen = 1'b1;
                cuif.pcSrc  = PCSRC_JAL;
            end
            HALT: cuif.halt = 1'b1;
            default: ;
        endcase
    end
endmodule

/* hw/operandUnit.sv */
`timescale 1ns/1ps

module operandUnit (
    input  logic                  CLK,
    input  logic                  arstN,
    input  cpuTypesPkg::regAddr_t rs,
    input  cpuTypesPkg::regAddr_t rt,
    input  logic [15:0]           imm16,
    operandIf.op                  opif,
    controlUnitIf.op              cuif
);
    import cpuTypesPkg::*;

    word_t regs [32];

    // ****************************************
    // Register file.
    // ****************************************
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (opif.wen && (opif.wAddr != '0)) begin
            regs[opif.wAddr] <= opif.wData;  // Register 0 is never written.
        end
    end

    // Reads see the value from before this cycle's write.
    assign opif.rsData = regs[rs];
    assign opif.rtData = regs[rt];

    // ****************************************
    // Immediate extension.
    // ****************************************
    always_comb begin
        if (cuif.extSel == SIGN_EXT) begin
            opif.immExt = {{16{imm16[15]}}, imm16};
        end else begin
            opif.immExt = {16'h0000, imm16};
        end
    end

    // Whatever the write-back stream does, register 0 stays zero.
    regZeroStaysZero: assert property (
        @(posedge CLK) disable iff (!arstN) regs[0] == '0
    );

endmodule

/* hw/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit #(
    parameter cpuTypesPkg::word_t resetPc = 32'h0000_0000
) (
    input  logic                  CLK,
    input  logic                  arstN,
    input  logic                  instrValid,
    input  cpuTypesPkg::regAddr_t rd,
    input  cpuTypesPkg::regAddr_t rt,
    input  logic [25:0]           target,
    input  logic [15:0]           imm16,
    input  cpuTypesPkg::word_t    memRData,
    operandIf.ex                  opif,
    controlUnitIf.ex              cuif,
    output cpuTypesPkg::word_t    pc,
    output logic                  memRen,
    output logic                  memWen,
    output logic                  memAtomic,
    output cpuTypesPkg::word_t    memAddr,
    output cpuTypesPkg::word_t    memWData,
    output logic                  wbValid,
    output cpuTypesPkg::regAddr_t wbAddr,
    output cpuTypesPkg::word_t    wbData,
    output logic                  halted
);
    import cpuTypesPkg::*;

    logic  fire;  // Instruction accepted this cycle.
    word_t aluB;
    word_t aluResult;
    word_t pcPlus4;
    word_t branchTarget;
    word_t nextPc;

    assign fire = instrValid && !halted;
    assign aluB = (cuif.aluSrc == ALUSRC_IMM) ? opif.immExt : opif.rtData;

    // ****************************************
    // ALU.
    // ****************************************
    always_comb begin
        case (cuif.aluOp)
            ALU_SLL:  aluResult = aluB << opif.rsData[4:0];  // Variable shifts move rt.
            ALU_SRL:  aluResult = aluB >> opif.rsData[4:0];
            ALU_ADD:  aluResult = opif.rsData + aluB;
            ALU_SUB:  aluResult = opif.rsData - aluB;
            ALU_AND:  aluResult = opif.rsData & aluB;
            ALU_OR:   aluResult = opif.rsData | aluB;
            ALU_XOR:  aluResult = opif.rsData ^ aluB;
            ALU_NOR:  aluResult = ~(opif.rsData | aluB);
            ALU_SLT:  aluResult = {31'b0, $signed(opif.rsData) < $signed(aluB)};
            ALU_SLTU: aluResult = {31'b0, opif.rsData < aluB};
            default:  aluResult = '0;
        endcase
    end

    // Write-back value and destination.
    always_comb begin
        case (cuif.regSrc)
            REGSRC_MEM: wbData = memRData;
            REGSRC_LUI: wbData = {imm16, 16'h0000};
            REGSRC_NPC: wbData = pcPlus4;
            default:    wbData = aluResult;
        endcase
        case (cuif.regDst)
            REGDST_RT: wbAddr = rt;
            REGDST_RA: wbAddr = 5'd31;
            default:   wbAddr = rd;
        endcase
    end

    assign wbValid    = fire && cuif.regWen;
    assign opif.wen   = wbValid;
    assign opif.wAddr = wbAddr;
    assign opif.wData = wbData;

    assign memRen    = fire && cuif.dRen;
    assign memWen    = fire && cuif.dWen;
    assign memAtomic = fire && cuif.atomic;
    assign memAddr   = aluResult;
    assign memWData  = opif.rtData;

    // ****************************************
    // Next PC.
    // ****************************************
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {opif.immExt[29:0], 2'b00};

    always_comb begin
        case (cuif.pcSrc)
            PCSRC_REG: nextPc = opif.rsData;
            PCSRC_BEQ: nextPc = (aluResult == '0) ? branchTarget : pcPlus4;
            PCSRC_BNE: nextPc = (aluResult != '0) ? branchTarget : pcPlus4;
            PCSRC_JAL: nextPc = {pcPlus4[31:28], target, 2'b00};
            default:   nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc     <= resetPc;
            halted <= 1'b0;
        end else if (fire) begin
            pc     <= nextPc;
            halted <= cuif.halt;  // Sticky, since no strobe is taken once set.
        end
    end

    noLoadAndStore: assert property (
        @(posedge CLK) disable iff (!arstN) !(memRen && memWen)
    );

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore #(
    parameter cpuTypesPkg::word_t resetPc = 32'h0000_0000
) (
    input  logic                  CLK,
    input  logic                  arstN,
    input  logic                  instrValid,
    input  cpuTypesPkg::word_t    instr,
    input  cpuTypesPkg::word_t    memRData,
    output cpuTypesPkg::word_t    pc,
    output logic                  memRen,
    output logic                  memWen,
    output logic                  memAtomic,
    output cpuTypesPkg::word_t    memAddr,
    output cpuTypesPkg::word_t    memWData,
    output logic                  wbValid,
    output cpuTypesPkg::regAddr_t wbAddr,
    output cpuTypesPkg::word_t    wbData,
    output logic                  halted
);
    import cpuTypesPkg::*;

    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    logic [15:0] imm16;
    logic [25:0] target;

    controlUnitIf cuif ();
    operandIf     opif ();

    // Instruction fields.
    assign cuif.opcode = opcode_t'(instr[31:26]);
    assign cuif.funct  = funct_t'(instr[5:0]);
    assign rs          = instr[25:21];
    assign rt          = instr[20:16];
    assign rd          = instr[15:11];
    assign imm16       = instr[15:0];
    assign target      = instr[25:0];

    controlUnit controlUnit_inst (
        .cuif (cuif)
    );

    operandUnit operandUnit_inst (
        .CLK   (CLK),
        .arstN (arstN),
        .rs    (rs),
        .rt    (rt),
        .imm16 (imm16),
        .opif  (opif),
        .cuif  (cuif)
    );

    executeUnit #(
        .resetPc (resetPc)
    ) executeUnit_inst (
        .CLK        (CLK),
        .arstN      (arstN),
        .instrValid (instrValid),
        .rd         (rd),
        .rt         (rt),
        .target     (target),
        .imm16      (imm16),
        .memRData   (memRData),
        .opif       (opif),
        .cuif       (cuif),
        .pc         (pc),
        .memRen     (memRen),
        .memWen     (memWen),
        .memAtomic  (memAtomic),
        .memAddr    (memAddr),
        .memWData   (memWData),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .halted     (halted)
    );

endmodule

/* tb/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb;
    import cpuTypesPkg::*;

    localparam int NumInstr = 2000;

    logic     CLK;
    logic     arstN;
    logic     instrValid;
    word_t    instr;
    word_t    memRData;
    word_t    pc, memAddr, memWData, wbData;
    logic     memRen, memWen, memAtomic, wbValid, halted;
    regAddr_t wbAddr;

    integer   seed;
    int       stepNo;

    // Reference model state.
    word_t    modelRegs [32];
    word_t    modelPc;
    logic     modelHalted;

    // Expected response for the current cycle.
    logic     expWb, expRen, expWen, expAtomic, expHalt;
    regAddr_t expWbAddr;
    word_t    expWbData, expAddr, expWData, expNextPc;

    opcode_t  opList [16] = '{J, JAL, BEQ, BNE, ADDI, ADDIU, SLTI, SLTIU,
                              ANDI, ORI, XORI, LUI, LW, SW, LL, SC};
    funct_t   fnList [16] = '{SLLV, SRLV, JR, ADD, ADDU, SUB, SUBU, AND,
                              OR, XOR, NOR, SLT, SLTU, ADDU, OR, SLTU};

    mipsCore #(.resetPc (32'h0000_0000)) mipsCore_inst (.*);

    always #2 CLK = ~CLK;

    function automatic word_t memAnswer(input word_t addr);
        word_t inv;
        inv = ~addr;
        return {inv[28:0], inv[31:29]};  // Inverted address rotated left by 3.
    endfunction

    always_comb memRData = memAnswer(memAddr);

    // ****************************************
    // Checks.
    // ****************************************
    task automatic failRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s at step %0d: expected %h, actual %h",
                              name, stepNo, expected, actual));
        end
    endtask

    task automatic checkReg(input string name, input regAddr_t expected, input regAddr_t actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s at step %0d: expected %0d, actual %0d",
                              name, stepNo, expected, actual));
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s at step %0d: expected %b, actual %b",
                              name, stepNo, expected, actual));
        end
    endtask

    // ****************************************
    // Reference model.
    // ****************************************
    task automatic predict(input word_t ins, input logic fire);
        opcode_t op;
        word_t   rsV;
        word_t   rtV;
        word_t   sImm;
        word_t   zImm;
        word_t   pc4;
        op        = opcode_t'(ins[31:26]);
        rsV       = modelRegs[ins[25:21]];
        rtV       = modelRegs[ins[20:16]];
        sImm      = {{16{ins[15]}}, ins[15:0]};
        zImm      = {16'h0000, ins[15:0]};
        pc4       = modelPc + 32'd4;
        expWb     = 1'b0;
        expRen    = 1'b0;
        expWen    = 1'b0;
        expAtomic = 1'b0;
        expHalt   = 1'b0;
        expWbAddr = ins[20:16];
        expWbData = '0;
        expAddr   = rsV + sImm;
        expWData  = rtV;
        expNextPc = fire ? pc4 : modelPc;  // Idle cycles hold the PC.
        if (fire) begin
            case (op)
                RTYPE: begin
                    expWb     = 1'b1;
                    expWbAddr = ins[15:11];
                    case (funct_t'(ins[5:0]))
                        SLLV:      expWbData = rtV << rsV[4:0];
                        SRLV:      expWbData = rtV >> rsV[4:0];
                        ADD, ADDU: expWbData = rsV + rtV;
                        SUB, SUBU: expWbData = rsV - rtV;
                        AND:       expWbData = rsV & rtV;
                        OR:        expWbData = rsV | rtV;
                        XOR:       expWbData = rsV ^ rtV;
                        NOR:       expWbData = ~(rsV | rtV);
                        SLT:       expWbData = {31'd0, $signed(rsV) < $signed(rtV)};
                        SLTU:      expWbData = {31'd0, rsV < rtV};
                        JR: begin
                            expWb     = 1'b0;
                            expNextPc = rsV;
                        end
                        default:   expWbData = '0;
                    endcase
                end
                BEQ: expNextPc = (rsV == rtV) ? pc4 + (sImm << 2) : pc4;
                BNE: expNextPc = (rsV != rtV) ? pc4 + (sImm << 2) : pc4;
                ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI: begin
                    expWb = 1'b1;
                    case (op)
                        SLTI:    expWbData = {31'd0, $signed(rsV) < $signed(sImm)};
                        SLTIU:   expWbData = {31'd0, rsV < sImm};
                        ANDI:    expWbData = rsV & zImm;
                        ORI:     expWbData = rsV | zImm;
                        XORI:    expWbData = rsV ^ zImm;
                        LUI:     expWbData = {ins[15:0], 16'h0000};
                        default: expWbData = rsV + sImm;
                    endcase
                end
                LW, LL: begin
                    expWb     = 1'b1;
                    expRen    = 1'b1;
                    expAtomic = (op == LL);
                    expWbData = memAnswer(expAddr);
                end
                SW, SC: begin
                    expWen    = 1'b1;
                    expAtomic = (op == SC);  // SC writes no register.
                end
                J: expNextPc = {pc4[31:28], ins[25:0], 2'b00};
                JAL: begin
                    expWb     = 1'b1;
                    expWbAddr = 5'd31;
                    expWbData = pc4;
                    expNextPc = {pc4[31:28], ins[25:0], 2'b00};
                end
                HALT: expHalt = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic resetModel();
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        modelPc     = '0;
        modelHalted = 1'b0;
    endtask

    // ****************************************
    // Stimulus.
    // ****************************************
    task automatic drawInstr(output word_t ins, output logic valid);
        word_t rnd;
        word_t sel;
        rnd = $random(seed);
        sel = $random(seed);
        if (sel[3:0] < 4'd5) begin
            ins = {RTYPE, rnd[25:6], fnList[sel[7:4]]};
        end else begin
            ins = {opList[sel[11:8]], rnd[25:0]};
        end
        valid = (sel[15:13] != 3'd0);  // About one cycle in eight stays idle.
    endtask

    task automatic runCycle(input word_t ins, input logic valid);
        logic fire;
        @(posedge CLK);
        #1;
        instrValid = valid;
        instr      = ins;
        #1;
        checkWord("pc", modelPc, pc);
        checkBit("halted", modelHalted, halted);
        fire = valid && !modelHalted;
        predict(ins, fire);
        checkBit("wbValid", expWb, wbValid);
        checkBit("memRen", expRen, memRen);
        checkBit("memWen", expWen, memWen);
        checkBit("memAtomic", expAtomic, memAtomic);
        if (expWb) begin
            checkReg("wbAddr", expWbAddr, wbAddr);
            checkWord("wbData", expWbData, wbData);
        end
        if (expRen || expWen) begin
            checkWord("memAddr", expAddr, memAddr);
        end
        if (expWen) begin
            checkWord("memWData", expWData, memWData);
        end
        if (fire) begin
            if (expWb && expWbAddr != 5'd0) begin
                modelRegs[expWbAddr] = expWbData;
            end
            modelPc     = expNextPc;
            modelHalted = expHalt;
        end
        stepNo++;
    endtask

    task automatic applyReset();
        int waited;
        @(posedge CLK);
        #1;
        arstN      = 1'b0;
        instrValid = 1'b0;
        repeat (4) @(posedge CLK);
        #1;
        arstN  = 1'b1;
        waited = 0;
        while (halted !== 1'b0) begin
            @(posedge CLK);
            #1;
            waited++;
            if (waited > 20) begin
                failRun("reset never released");
            end
        end
        resetModel();
        #1;
        checkWord("pc after reset", 32'h0000_0000, pc);
        checkBit("halted after reset", 1'b0, halted);
        checkBit("wbValid after reset", 1'b0, wbValid);
        checkBit("memRen after reset", 1'b0, memRen);
        checkBit("memWen after reset", 1'b0, memWen);
    endtask

    initial begin
        word_t ins;
        logic  valid;
        seed       = 69312;
        stepNo     = 0;
        CLK        = 1'b0;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        resetModel();
        applyReset();
        for (int i = 0; i < NumInstr; i++) begin
            drawInstr(ins, valid);
            runCycle(ins, valid);
        end
        runCycle({HALT, 26'd0}, 1'b1);
        // Every strobe from here on must be ignored.
        for (int i = 0; i < 40; i++) begin
            drawInstr(ins, valid);
            runCycle(ins, 1'b1);
        end
        applyReset();
        for (int i = 0; i < 100; i++) begin
            drawInstr(ins, valid);
            runCycle(ins, valid);
        end
        @(posedge CLK);
        #1;
        instrValid = 1'b0;
        #1;
        checkWord("final pc", modelPc, pc);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* mipsCore.f */
hw/cpuTypesPkg.sv
hw/controlUnitIf.sv
hw/operandIf.sv
hw/controlUnit.sv
hw/operandUnit.sv
hw/executeUnit.sv
hw/mipsCore.sv
tb/mipsCoreTb.sv

/* Makefile */
# Verilator build and run of the core testbench.

VERILATOR ?= verilator
TOP       ?= mipsCoreTb
FLAGS     ?= --assert

.PHONY: sim clean

# The run passes only when the pass line shows up in the output.
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f mipsCore.f
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir
